/* Makefile */
# Verilator build and run of the Ising annealer core testbench

VERILATOR ?= verilator
TOP       ?= tb_ising_core
FILELIST  ?= ising_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf $(OBJ_DIR)

/* ising_core.f */
ising_pkg.sv
ising_host_xbar.sv
ising_l1_mem.sv
ising_seq_fsm.sv
ising_step_timer.sv
ising_weight_loader.sv
ising_spin_update.sv
ising_core.sv
tb_ising_core.sv

/* ising_core.sv */
////////////////////////////////////////////////////////////
// top level of the Ising annealer core, host write port,
// start port with a run configuration, analog write lines
// and the spin result stream
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ising_core (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           host_valid_i,
    output logic                           host_ready_o,
    input  ising_pkg::host_wr_t            host_req_i,
    output logic                           host_err_o,
    input  logic                           start_valid_i,
    output logic                           start_ready_o,
    input  ising_pkg::run_cfg_t            start_cfg_i,
    output ising_pkg::analog_wr_t          analog_o,
    output logic                           spin_valid_o,
    input  logic                           spin_ready_i,
    output logic [ising_pkg::NUM_SPIN-1:0] spin_o
);
    import ising_pkg::*;

    seq_state_e          state;
    run_cfg_t            run_cfg;
    logic                start_fire;
    logic                j_we;
    logic                flip_we;
    logic [IDX_W-1:0]    waddr;
    logic [J_ROW_W-1:0]  wdata;
    logic [IDX_W-1:0]    index;
    logic                j_ren;
    logic [J_ROW_W-1:0]  j_rdata;
    logic                flip_ren;
    logic                flip_rvalid;
    logic [FLIP_AW-1:0]  flip_raddr;
    logic [NUM_SPIN-1:0] flip_rdata;
    logic                hold_done;
    logic                row_last;
    logic                icon_last;
    logic                result_taken;

    ////////////////////////////////////////////////////////////
    // host path and L1 memories
    ////////////////////////////////////////////////////////////
    ising_host_xbar u_host_xbar (
        .host_valid_i (host_valid_i),
        .host_req_i   (host_req_i),
        .state_i      (state),
        .host_ready_o (host_ready_o),
        .host_err_o   (host_err_o),
        .j_we_o       (j_we),
        .flip_we_o    (flip_we),
        .waddr_o      (waddr),
        .wdata_o      (wdata)
    );

    ising_l1_mem #(.DEPTH(NUM_SPIN), .WIDTH(J_ROW_W)) u_j_mem (
        .clk_i   (clk_i),
        .we_i    (j_we),
        .waddr_i (waddr),
        .wdata_i (wdata),
        .re_i    (j_ren),
        .raddr_i (index),
        .rdata_o (j_rdata)
    );

    ising_l1_mem #(.DEPTH(FLIP_DEPTH), .WIDTH(NUM_SPIN)) u_flip_mem (
        .clk_i   (clk_i),
        .we_i    (flip_we),
        .waddr_i (waddr[FLIP_AW-1:0]),
        .wdata_i (wdata[NUM_SPIN-1:0]),
        .re_i    (flip_ren),
        .raddr_i (flip_raddr),
        .rdata_o (flip_rdata)
    );

    ////////////////////////////////////////////////////////////
    // sequencer, timer and datapaths
    ////////////////////////////////////////////////////////////
    ising_seq_fsm u_seq_fsm (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .start_valid_i  (start_valid_i),
        .start_ready_o  (start_ready_o),
        .cfg_i          (start_cfg_i),
        .cfg_o          (run_cfg),
        .start_fire_o   (start_fire),
        .row_last_i     (row_last),
        .icon_last_i    (icon_last),
        .hold_done_i    (hold_done),
        .result_taken_i (result_taken),
        .index_i        (index),
        .mem_we_i       ({flip_we, j_we}),
        .state_o        (state),
        .j_ren_o        (j_ren),
        .flip_ren_o     (flip_ren),
        .flip_rvalid_o  (flip_rvalid),
        .flip_raddr_o   (flip_raddr)
    );

    ising_step_timer u_step_timer (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .state_i        (state),
        .cfg_i          (run_cfg),
        .result_taken_i (result_taken),
        .index_o        (index),
        .hold_done_o    (hold_done),
        .row_last_o     (row_last),
        .icon_last_o    (icon_last)
    );

    ising_weight_loader u_weight_loader (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .state_i   (state),
        .index_i   (index),
        .j_rdata_i (j_rdata),
        .analog_o  (analog_o)
    );

    ising_spin_update u_spin_update (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .start_fire_i   (start_fire),
        .spin_init_i    (start_cfg_i.spin_init),
        .flip_rvalid_i  (flip_rvalid),
        .flip_rdata_i   (flip_rdata),
        .spin_valid_o   (spin_valid_o),
        .spin_ready_i   (spin_ready_i),
        .spin_o         (spin_o),
        .result_taken_o (result_taken)
    );

endmodule

/* ising_host_xbar.sv */
////////////////////////////////////////////////////////////
// host write decoder, steers each write beat onto the J
// memory or the flip memory and flags unmapped addresses
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ising_host_xbar (
    input  logic                          host_valid_i,
    input  ising_pkg::host_wr_t           host_req_i,
    input  ising_pkg::seq_state_e         state_i,
    output logic                          host_ready_o,
    output logic                          host_err_o,
    output logic                          j_we_o,
    output logic                          flip_we_o,
    output logic [ising_pkg::IDX_W-1:0]   waddr_o,
    output logic [ising_pkg::J_ROW_W-1:0] wdata_o
);
    import ising_pkg::*;

    logic [ADDR_W-1:0] j_off;
    logic [ADDR_W-1:0] flip_off;
    logic              j_hit;
    logic              flip_hit;
    logic              fire;

    assign host_ready_o = (state_i == IDLE);  // memories belong to the sequencer otherwise
    assign fire         = host_valid_i & host_ready_o;

    // offsets below a base wrap around and miss the range check
    assign j_off    = host_req_i.addr - J_BASE;
    assign flip_off = host_req_i.addr - FLIP_BASE;
    assign j_hit    = (j_off < ADDR_W'(NUM_SPIN));
    assign flip_hit = (flip_off < ADDR_W'(FLIP_DEPTH));

    assign j_we_o     = fire & j_hit;
    assign flip_we_o  = fire & flip_hit;
    assign host_err_o = fire & ~j_hit & ~flip_hit;

    assign waddr_o = host_req_i.addr[IDX_W-1:0];  // both bases are aligned to their region
    assign wdata_o = host_req_i.data;

endmodule

/* ising_l1_mem.sv */
////////////////////////////////////////////////////////////
// simple dual port L1 memory, one write port and one read
// port, read data registered one cycle after re_i
// rdata_o holds its value while re_i is low
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ising_l1_mem #(
    parameter int  DEPTH = 16,
    parameter int  WIDTH = 32,
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic             clk_i,
    input  logic             we_i,
    input  logic [AW-1:0]    waddr_i,
    input  logic [WIDTH-1:0] wdata_i,
    input  logic             re_i,
    input  logic [AW-1:0]    raddr_i,
    output logic [WIDTH-1:0] rdata_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (re_i) begin
            rdata_o <= mem[raddr_i];  // one cycle of read latency
        end
    end

endmodule

/* ising_pkg.sv */
////////////////////////////////////////////////////////////
// shared sizes, address map and port structs of the Ising
// annealer core, imported by every block of the core
////////////////////////////////////////////////////////////

package ising_pkg;

    localparam int NUM_SPIN   = 16;
    localparam int BIT_J      = 4;
    localparam int J_ROW_W    = NUM_SPIN * BIT_J;    // one coupling row
    localparam int FLIP_DEPTH = 8;
    localparam int ADDR_W     = 8;
    localparam int CNT_W      = 8;

    localparam int IDX_W   = $clog2(NUM_SPIN);       // row index, also covers icons
    localparam int FLIP_AW = $clog2(FLIP_DEPTH);
    localparam int ICON_W  = $clog2(FLIP_DEPTH + 1); // icon count 1..FLIP_DEPTH

    // host address map, one word per row or icon
    localparam logic [ADDR_W-1:0] J_BASE    = 8'h00;
    localparam logic [ADDR_W-1:0] FLIP_BASE = 8'h10;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,    // J rows onto the analog write lines
        COMPUTE, // flip icons into the spin register
        DONE
    } seq_state_e;

    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [J_ROW_W-1:0] data;   // icons use the low NUM_SPIN bits
    } host_wr_t;

    typedef struct packed {
        logic [ICON_W-1:0]   icon_count;
        logic [CNT_W-1:0]    dt_cycles;    // hold per J row, at least 1
        logic [CNT_W-1:0]    cmpt_cycles;  // gap after each result
        logic [NUM_SPIN-1:0] spin_init;
    } run_cfg_t;

    typedef struct packed {
        logic [NUM_SPIN-1:0] j_wwl;  // one-hot row select
        logic [J_ROW_W-1:0]  wbl;
    } analog_wr_t;

endpackage

/* ising_seq_fsm.sv */
////////////////////////////////////////////////////////////
// phase sequencer of the core, IDLE -> LOAD -> COMPUTE ->
// DONE, latches the run configuration at start and issues
// the J row reads and the flip icon reads
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ising_seq_fsm (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          start_valid_i,
    output logic                          start_ready_o,
    input  ising_pkg::run_cfg_t           cfg_i,
    output ising_pkg::run_cfg_t           cfg_o,
    output logic                          start_fire_o,
    input  logic                          row_last_i,
    input  logic                          icon_last_i,
    input  logic                          hold_done_i,
    input  logic                          result_taken_i,
    input  logic [ising_pkg::IDX_W-1:0]   index_i,
    input  logic [1:0]                    mem_we_i,     // {flip, j} host writes
    output ising_pkg::seq_state_e         state_o,
    output logic                          j_ren_o,
    output logic                          flip_ren_o,
    output logic                          flip_rvalid_o,
    output logic [ising_pkg::FLIP_AW-1:0] flip_raddr_o
);
    import ising_pkg::*;

    seq_state_e state_q;
    seq_state_e state_d;
    run_cfg_t   cfg_q;
    logic       rd_go_q;  // pulses once per icon

    assign start_ready_o = (state_q == IDLE);
    assign start_fire_o  = start_valid_i & start_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start_fire_o) state_d = LOAD;
            LOAD:    if (hold_done_i && row_last_i) state_d = COMPUTE;
            COMPUTE: if (result_taken_i && icon_last_i) state_d = DONE;
            default: state_d = IDLE;  // DONE lasts one cycle
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q       <= IDLE;
            rd_go_q       <= 1'b0;
            flip_rvalid_o <= 1'b0;
        end else begin
            state_q       <= state_d;
            // first read right after the last row, then one per finished gap
            rd_go_q       <= (state_q == LOAD && hold_done_i && row_last_i) ||
                             (state_q == COMPUTE && hold_done_i && !icon_last_i);
            flip_rvalid_o <= flip_ren_o;  // matches memory read latency
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_fire_o) begin
            cfg_q <= cfg_i;
        end
    end

    assign cfg_o        = cfg_q;
    assign state_o      = state_q;
    assign j_ren_o      = (state_q == LOAD);  // row index is stable over its hold
    assign flip_ren_o   = rd_go_q;
    assign flip_raddr_o = index_i[FLIP_AW-1:0];

    // the host must never write a memory that the sequencer is reading
    a_host_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (mem_we_i != 2'b00) |-> (state_q == IDLE));

endmodule

/* ising_spin_update.sv */
////////////////////////////////////////////////////////////
// spin register, loaded with spin_init at start and XORed
// with each flip icon, every update goes out as one beat
// of a valid/ready stream
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ising_spin_update (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           start_fire_i,
    input  logic [ising_pkg::NUM_SPIN-1:0] spin_init_i,
    input  logic                           flip_rvalid_i,
    input  logic [ising_pkg::NUM_SPIN-1:0] flip_rdata_i,
    output logic                           spin_valid_o,
    input  logic                           spin_ready_i,
    output logic [ising_pkg::NUM_SPIN-1:0] spin_o,
    output logic                           result_taken_o
);

    assign result_taken_o = spin_valid_o & spin_ready_i;

    always_ff @(posedge clk_i) begin
        if (start_fire_i) begin
            spin_o <= spin_init_i;
        end else if (flip_rvalid_i) begin
            spin_o <= spin_o ^ flip_rdata_i;  // flip the marked spins
        end
    end

    // the sequencer issues no new icon before the handshake
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            spin_valid_o <= 1'b0;
        end else if (flip_rvalid_i) begin
            spin_valid_o <= 1'b1;
        end else if (result_taken_o) begin
            spin_valid_o <= 1'b0;
        end
    end

    a_stall_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (spin_valid_o && !spin_ready_i) |=> (spin_valid_o && $stable(spin_o)));

endmodule

/* ising_step_timer.sv */
////////////////////////////////////////////////////////////
// cycle timer of both phases, holds each J row for
// dt_cycles and waits cmpt_cycles after each result,
// the row or icon index advances when a hold ends
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ising_step_timer (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  ising_pkg::seq_state_e       state_i,
    input  ising_pkg::run_cfg_t         cfg_i,
    input  logic                        result_taken_i,
    output logic [ising_pkg::IDX_W-1:0] index_o,
    output logic                        hold_done_o,
    output logic                        row_last_o,
    output logic                        icon_last_o
);
    import ising_pkg::*;

    logic [CNT_W-1:0] cnt_q;
    logic             holding_q;  // inside the gap after a result

    always_comb begin
        hold_done_o = 1'b0;
        if (state_i == LOAD) begin
            hold_done_o = (cnt_q == cfg_i.dt_cycles - CNT_W'(1));
        end else if (state_i == COMPUTE) begin
            // a zero gap ends on the handshake itself
            hold_done_o = holding_q ? (cnt_q == cfg_i.cmpt_cycles - CNT_W'(1))
                                    : (result_taken_i && cfg_i.cmpt_cycles == '0);
        end
    end

    assign row_last_o  = (index_o == IDX_W'(NUM_SPIN - 1));
    assign icon_last_o = (index_o == IDX_W'(cfg_i.icon_count - 1'b1));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q     <= '0;
            holding_q <= 1'b0;
            index_o   <= '0;
        end else if (state_i == LOAD || state_i == COMPUTE) begin
            if (hold_done_o) begin
                cnt_q     <= '0;
                holding_q <= 1'b0;
                index_o   <= (state_i == LOAD && row_last_o) ? '0 : index_o + 1'b1;
            end else if (state_i == LOAD || holding_q) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (result_taken_i) begin
                holding_q <= 1'b1;
            end
        end else begin
            cnt_q     <= '0;  // idle and done start every run from zero
            holding_q <= 1'b0;
            index_o   <= '0;
        end
    end

endmodule

/* ising_weight_loader.sv */
////////////////////////////////////////////////////////////
// drives the analog write lines in LOAD, the word line is
// registered alongside the J memory read so wbl and j_wwl
// line up one cycle after each read
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ising_weight_loader (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  ising_pkg::seq_state_e         state_i,
    input  logic [ising_pkg::IDX_W-1:0]   index_i,
    input  logic [ising_pkg::J_ROW_W-1:0] j_rdata_i,  // row held in the memory read register
    output ising_pkg::analog_wr_t         analog_o
);
    import ising_pkg::*;

    logic [NUM_SPIN-1:0] wwl_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wwl_q <= '0;
        end else if (state_i == LOAD) begin
            wwl_q <= {{(NUM_SPIN-1){1'b0}}, 1'b1} << index_i;
        end else begin
            wwl_q <= '0;
        end
    end

    assign analog_o.j_wwl = wwl_q;
    assign analog_o.wbl   = (|wwl_q) ? j_rdata_i : '0;  // quiet bit lines outside LOAD

    a_wwl_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(analog_o.j_wwl));

    // rows only hold, step up by one, or end
    a_wwl_order: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (analog_o.j_wwl != '0) |=> (analog_o.j_wwl == '0) ||
        (analog_o.j_wwl == $past(analog_o.j_wwl)) ||
        (analog_o.j_wwl == $past(analog_o.j_wwl) << 1));

endmodule

/* tb_ising_core.sv */
////////////////////////////////////////////////////////////
// directed testbench of the Ising annealer core, fills the
// memories over the host port, starts runs and checks the
// analog rows and spin results against a reference model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ising_core;
    import ising_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int DT_MAX     = 3;
    localparam int CMPT_MAX   = 2;
    localparam int STALL_MAX  = 6;   // longest random back-pressure
    localparam int RUN_MAX    = NUM_SPIN * DT_MAX + FLIP_DEPTH * (CMPT_MAX + STALL_MAX + 6) + 8;
    localparam int WDOG_CYC   = 8 + 2 * (NUM_SPIN + FLIP_DEPTH + 4) + 3 * RUN_MAX + 200;

    typedef logic [$bits(analog_wr_t)-1:0] word_t;  // widest value compared

    logic                clk;
    logic                arst_n;
    logic                host_valid;
    logic                host_ready;
    host_wr_t            host_req;
    logic                host_err;
    logic                start_valid;
    logic                start_ready;
    run_cfg_t            start_cfg;
    analog_wr_t          analog;
    logic                spin_valid;
    logic                spin_ready;
    logic [NUM_SPIN-1:0] spin;

    logic [J_ROW_W-1:0]  j_model [NUM_SPIN];
    logic [NUM_SPIN-1:0] flip_model [FLIP_DEPTH];
    int                  errors = 0;
    int                  checks = 0;

    ising_core u_ising_core (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .host_valid_i  (host_valid),
        .host_ready_o  (host_ready),
        .host_req_i    (host_req),
        .host_err_o    (host_err),
        .start_valid_i (start_valid),
        .start_ready_o (start_ready),
        .start_cfg_i   (start_cfg),
        .analog_o      (analog),
        .spin_valid_o  (spin_valid),
        .spin_ready_i  (spin_ready),
        .spin_o        (spin)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // checkers
    ////////////////////////////////////////////////////////////
    task automatic check_eq(input word_t got, input word_t exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR at %0t ns: %s", $time, what);
        end
    endtask

    task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [J_ROW_W-1:0] data,
                              input logic exp_err);
        @(negedge clk);
        host_valid    = 1'b1;
        host_req.addr = addr;
        host_req.data = data;
        #1;  // combinational flags settle inside the cycle
        check_eq(word_t'(host_ready), word_t'(1), "host_ready_o during write");
        check_eq(word_t'(host_err), word_t'(exp_err), "host_err_o for write");
    endtask

    ////////////////////////////////////////////////////////////
    // one full run, load phase then compute phase
    ////////////////////////////////////////////////////////////
    task automatic run_anneal(input int dt, input int cmpt, input int icons, input logic bp);
        run_cfg_t            cfg;
        logic [NUM_SPIN-1:0] exp_spin;
        logic [NUM_SPIN-1:0] held_spin;
        logic                held;
        logic                take;
        int                  n;
        int                  stall;
        int                  cyc;
        cfg.icon_count  = ICON_W'(icons);
        cfg.dt_cycles   = CNT_W'(dt);
        cfg.cmpt_cycles = CNT_W'(cmpt);
        cfg.spin_init   = NUM_SPIN'($urandom);
        exp_spin        = cfg.spin_init;
        @(negedge clk);
        start_valid = 1'b1;
        start_cfg   = cfg;
        #1;
        check_eq(word_t'(start_ready), word_t'(1), "start_ready_o before start");
        @(negedge clk);
        start_valid = 1'b0;
        check_eq(word_t'(analog), '0, "analog_o one cycle after start");
        check_eq(word_t'(start_ready), '0, "start_ready_o in LOAD");
        // rows follow back to back, each held dt cycles
        for (int k = 0; k < NUM_SPIN; k++) begin
            for (int t = 0; t < dt; t++) begin
                @(negedge clk);
                check_eq(word_t'(analog.j_wwl), word_t'(NUM_SPIN'(1) << k), "j_wwl row select");
                check_eq(word_t'(analog.wbl), word_t'(j_model[k]), "wbl row data");
                check_eq(word_t'({host_ready, start_ready}), '0, "readies in LOAD");
            end
        end
        n         = 0;
        stall     = 0;
        cyc       = 0;
        held      = 1'b0;
        held_spin = '0;
        while (n < icons && cyc < RUN_MAX) begin
            @(negedge clk);
            cyc++;
            check_eq(word_t'(analog), '0, "analog_o in COMPUTE");
            check_eq(word_t'({host_ready, start_ready}), '0, "readies in COMPUTE");
            take = !bp || stall >= STALL_MAX || ($urandom % 2 == 0);
            if (spin_valid) begin
                if (held) begin
                    check_eq(word_t'(spin), word_t'(held_spin), "spin_o under back-pressure");
                end
                if (take) begin
                    exp_spin = exp_spin ^ flip_model[n];  // icons accumulate in order
                    check_eq(word_t'(spin), word_t'(exp_spin), "spin result");
                    n++;
                    held  = 1'b0;
                    stall = 0;
                end else begin
                    held      = 1'b1;
                    held_spin = spin;
                    stall++;
                end
            end
            spin_ready = take;
        end
        check_true(n == icons, "spin results missing, COMPUTE did not finish");
        @(negedge clk);
        spin_ready = 1'b0;
        check_eq(word_t'(spin_valid), '0, "spin_valid_o after last result");
        check_eq(word_t'({host_ready, start_ready}), '0, "readies in DONE");
        @(negedge clk);
        check_eq(word_t'({host_ready, start_ready}), word_t'(3), "readies after DONE");
        check_eq(word_t'(spin_valid), '0, "spin_valid_o back in IDLE");
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////
    task automatic test_reset_state();
        check_eq(word_t'({host_ready, start_ready}), word_t'(3), "readies after reset");
        check_eq(word_t'({spin_valid, host_err}), '0, "valid and err after reset");
        check_eq(word_t'(analog), '0, "analog_o after reset");
    endtask

    task automatic test_host_writes();
        logic [J_ROW_W-1:0] data;
        for (int k = 0; k < NUM_SPIN; k++) begin
            j_model[k] = {$urandom(), $urandom()};
            host_write(ADDR_W'(J_BASE + k), j_model[k], 1'b0);
        end
        for (int k = 0; k < FLIP_DEPTH; k++) begin
            data          = {$urandom(), $urandom()};
            flip_model[k] = data[NUM_SPIN-1:0];
            host_write(ADDR_W'(FLIP_BASE + k), data, 1'b0);
        end
        // just past the flip region, and one that aliases row 3 in its low bits
        host_write(8'h18, {$urandom(), $urandom()}, 1'b1);
        host_write(8'h93, {$urandom(), $urandom()}, 1'b1);
        @(negedge clk);
        host_valid = 1'b0;
    endtask

    task automatic test_load_and_compute();
        run_anneal(1, 0, FLIP_DEPTH, 1'b0);
    endtask

    task automatic test_back_pressure();
        run_anneal(DT_MAX, CMPT_MAX, 6, 1'b1);
    endtask

    task automatic test_busy_and_restart();
        logic [J_ROW_W-1:0] data;
        data       = {$urandom(), $urandom()};
        j_model[5] = data;
        host_write(ADDR_W'(J_BASE + 5), data, 1'b0);
        data          = {$urandom(), $urandom()};
        flip_model[0] = data[NUM_SPIN-1:0];
        host_write(FLIP_BASE, data, 1'b0);
        @(negedge clk);
        host_valid = 1'b0;
        run_anneal(2, 1, 3, 1'b1);
    endtask

    initial begin
        void'($urandom(32'hedbd574d));
        arst_n      = 1'b0;
        host_valid  = 1'b0;
        host_req    = '0;
        start_valid = 1'b0;
        start_cfg   = '0;
        spin_ready  = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_reset_state();
        test_host_writes();
        test_load_and_compute();
        test_back_pressure();
        test_busy_and_restart();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog sized from the longest possible runs
    initial begin
        #(WDOG_CYC * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WDOG_CYC);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    end

endmodule
